// File: Bender.yml
package:
  name: uart

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/uart_pkg.sv
      - hw/uart_baud_gen.sv
      - uart/uart_rx.sv
      - uart/uart_tx.sv
      - hw/uart_fifo.sv
      - hw/uart_wb_regs.sv
      - hw/uart_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/uart_chk.sv
      - test/tb_uart.sv

// File: common/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Entries per FIFO, power of two
`define UART_FIFO_DEPTH 8

// Divisor after reset, tick every second clock
`define UART_DIV_RESET 1

// Word offsets on the Wishbone bus
`define UART_REG_DATA 0
`define UART_REG_STATUS 1
`define UART_REG_DIV 2

// STATUS register bits
`define UART_ST_RX_VALID 0
`define UART_ST_TX_FULL 1
`define UART_ST_TX_EMPTY 2
`define UART_ST_PAR_ERR 3
`define UART_ST_FRM_ERR 4

`endif

// File: common/uart_pkg.sv
package uart_pkg;

    // One received 8E1 frame as it sits in the receive FIFO
    typedef struct packed {
        logic       frm_err;
        logic       par_err;
        logic [7:0] data;
    } rx_frame_t;

    typedef logic [7:0] tx_byte_t;

    // Clocks per sample tick, minus one
    typedef logic [15:0] divisor_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_BIT,
        RX_SHIFT,
        RX_STOP,
        RX_SAVE
    } rx_state_t;

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

endpackage

// File: compile.f
+incdir+common
common/uart_pkg.sv
hw/uart_baud_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
hw/uart_fifo.sv
hw/uart_wb_regs.sv
hw/uart_top.sv
test/uart_chk.sv
test/tb_uart.sv

// File: hw/uart_baud_gen.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_baud_gen
    import uart_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  divisor_t divisor,
    input  logic     div_load,
    output logic     sample_tick
);

    divisor_t cnt;

    // Down-counter, reload on zero or on a fresh divisor
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            cnt <= divisor_t'(`UART_DIV_RESET);
        else if (div_load || cnt == '0)
            cnt <= divisor;
        else
            cnt <= cnt - 1'b1;
    end

    assign sample_tick = (cnt == '0);

endmodule

// File: hw/uart_fifo.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `UART_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int AW = $clog2(DEPTH);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    // Overflow and underflow requests are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(DEPTH));

endmodule

// File: hw/uart_top.sv
`timescale 1ns/1ps

module uart_top
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        rxd,
    output logic        txd
);

    rx_frame_t rx_frame;
    rx_frame_t rx_head;
    tx_byte_t  tx_data;
    tx_byte_t  tx_head;
    divisor_t  divisor;
    logic      frame_valid;
    logic      rx_pop;
    logic      rx_empty;
    logic      rx_full;
    logic      tx_push;
    logic      tx_pop;
    logic      tx_empty;
    logic      tx_full;
    logic      tx_busy;
    logic      div_load;
    logic      sample_tick;

    uart_wb_regs u_regs (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .rx_head  (rx_head),
        .rx_empty (rx_empty),
        .tx_full  (tx_full),
        .tx_busy  (tx_busy),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .rx_pop   (rx_pop),
        .tx_push  (tx_push),
        .tx_data  (tx_data),
        .divisor  (divisor),
        .div_load (div_load)
    );

    uart_baud_gen u_baud (
        .clk         (clk),
        .rstn        (rstn),
        .divisor     (divisor),
        .div_load    (div_load),
        .sample_tick (sample_tick)
    );

    // Receive path
    uart_rx u_rx (
        .clk         (clk),
        .rstn        (rstn),
        .sample_tick (sample_tick),
        .rxd         (rxd),
        .frame_valid (frame_valid),
        .frame       (rx_frame)
    );

    uart_fifo #(.payload_t(rx_frame_t)) rx_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .push      (frame_valid),
        .push_data (rx_frame),
        .pop       (rx_pop),
        .head      (rx_head),
        .empty     (rx_empty),
        .full      (rx_full)
    );

    // Transmit path
    uart_fifo #(.payload_t(tx_byte_t)) tx_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .push      (tx_push),
        .push_data (tx_data),
        .pop       (tx_pop),
        .head      (tx_head),
        .empty     (tx_empty),
        .full      (tx_full)
    );

    uart_tx u_tx (
        .clk         (clk),
        .rstn        (rstn),
        .sample_tick (sample_tick),
        .tx_empty    (tx_empty),
        .tx_head     (tx_head),
        .tx_pop      (tx_pop),
        .txd         (txd),
        .tx_busy     (tx_busy)
    );

endmodule

// File: hw/uart_wb_regs.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_wb_regs
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    input  rx_frame_t   rx_head,
    input  logic        rx_empty,
    input  logic        tx_full,
    input  logic        tx_busy,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        rx_pop,
    output logic        tx_push,
    output tx_byte_t    tx_data,
    output divisor_t    divisor,
    output logic        div_load
);

    logic        sel_data;
    logic        sel_status;
    logic        sel_div;
    logic        wr_acc;
    logic        rd_acc;
    logic [31:0] status;
    logic [31:0] rd_data;

    ////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////

    // One ack per request, then a dead cycle
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end

    // Byte address, word offsets
    assign sel_data   = (wb_adr[31:2] == 30'(`UART_REG_DATA));
    assign sel_status = (wb_adr[31:2] == 30'(`UART_REG_STATUS));
    assign sel_div    = (wb_adr[31:2] == 30'(`UART_REG_DIV));

    assign wr_acc = wb_ack && wb_we;
    assign rd_acc = wb_ack && !wb_we;

    // FIFO strobes land on the ack edge
    assign tx_push = wr_acc && sel_data && !tx_full;
    assign tx_data = wb_dat_w[7:0];
    assign rx_pop  = rd_acc && sel_data && !rx_empty;

    ////////////////////////////////////////
    // Divisor
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            divisor  <= divisor_t'(`UART_DIV_RESET);
            div_load <= 1'b0;
        end
        else
        begin
            if (wr_acc && sel_div)
                divisor <= wb_dat_w[15:0];
            // Restart the tick counter once the new value is in place
            div_load <= wr_acc && sel_div;
        end
    end

    ////////////////////////////////////////
    // Read data
    ////////////////////////////////////////

    always_comb
    begin
        status                    = '0;
        status[`UART_ST_RX_VALID] = !rx_empty;
        status[`UART_ST_TX_FULL]  = tx_full;
        status[`UART_ST_TX_EMPTY] = !tx_busy;
        // Error flags only mean something with a frame at the head
        status[`UART_ST_PAR_ERR]  = !rx_empty && rx_head.par_err;
        status[`UART_ST_FRM_ERR]  = !rx_empty && rx_head.frm_err;
    end

    always_comb
    begin
        rd_data = '0;
        if (sel_data && !rx_empty)
            rd_data = 32'(rx_head);
        else if (sel_status)
            rd_data = status;
        else if (sel_div)
            rd_data = {16'd0, divisor};
    end

    assign wb_dat_r = wb_ack ? rd_data : '0;

endmodule

// File: test/tb_uart.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module tb_uart;

    localparam logic [31:0] ADR_DATA   = `UART_REG_DATA * 4;
    localparam logic [31:0] ADR_STATUS = `UART_REG_STATUS * 4;
    localparam logic [31:0] ADR_DIV    = `UART_REG_DIV * 4;
    localparam int          ACK_LIMIT  = 8;
    localparam int          POLL_LIMIT = 2000;

    logic        clk;
    logic        rstn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        rxd;
    logic        txd;
    logic        loopback;
    logic        line_drv;

    logic [31:0] lfsr_state;
    int          cur_div;

    // Pending compare, filled by the sequence
    logic        cmp_req;
    string       cmp_name;
    logic [31:0] cmp_got;
    logic [31:0] cmp_exp;

    uart_top dut (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .rxd      (rxd),
        .txd      (txd)
    );

    // Line mux, loopback or driven frames
    assign rxd = loopback ? txd : line_drv;

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model and checking
    ////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i] = lfsr_state[0];
        end
    endtask

    // DATA or STATUS value for a frame at the receive head, transmitter idle
    function automatic logic [31:0] expected_read(input logic [31:0] adr, input logic [7:0] d,
                                                  input logic par_bit, input logic stop_bit);
        logic        par_err;
        logic        frm_err;
        logic [31:0] val;
        // 8E1: ones over data and parity must be even
        par_err = ^{par_bit, d};
        frm_err = !stop_bit;
        val = '0;
        if (adr == ADR_DATA)
            val = {22'd0, frm_err, par_err, d};
        else if (adr == ADR_STATUS)
        begin
            val[`UART_ST_RX_VALID] = 1'b1;
            val[`UART_ST_TX_EMPTY] = 1'b1;
            val[`UART_ST_PAR_ERR]  = par_err;
            val[`UART_ST_FRM_ERR]  = frm_err;
        end
        return val;
    endfunction

    task automatic fail_now();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            fail_now();
        end
    endtask

    // Compare process, also watches the bound assertions
    always @(negedge clk)
    begin
        if (cmp_req)
        begin
            cmp_req = 1'b0;
            check_value(cmp_name, cmp_got, cmp_exp);
        end
        if (dut.u_chk.fail_cnt != 0)
        begin
            $display("ERROR: an assertion in uart_chk failed at %0t", $time);
            fail_now();
        end
    end

    ////////////////////////////////////////
    // Bus and line tasks
    ////////////////////////////////////////

    // Entered and left 2 ns after a rising edge
    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack && n < ACK_LIMIT)
        begin
            n++;
            @(negedge clk);
        end
        if (!wb_ack)
        begin
            $display("ERROR: no Wishbone ack for access to address 0x%08h", adr);
            fail_now();
        end
        rdata = wb_dat_r;
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input logic [31:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'd0, data);
    endtask

    task automatic post_compare(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        cmp_name = name;
        cmp_got  = got;
        cmp_exp  = exp;
        cmp_req  = 1'b1;
    endtask

    task automatic read_expect(input logic [31:0] adr, input logic [31:0] exp,
                               input string name);
        logic [31:0] got;
        read_reg(adr, got);
        post_compare(name, got, exp);
    endtask

    task automatic wait_rx_ready(output logic [31:0] st);
        int n;
        n = 0;
        read_reg(ADR_STATUS, st);
        while (!st[`UART_ST_RX_VALID] && n < POLL_LIMIT)
        begin
            n++;
            read_reg(ADR_STATUS, st);
        end
        if (!st[`UART_ST_RX_VALID])
        begin
            $display("ERROR: receive FIFO stayed empty at %0t", $time);
            fail_now();
        end
    endtask

    task automatic hold_line(input logic level, input int clks);
        line_drv = level;
        repeat (clks) @(posedge clk);
        #2;
    endtask

    // One frame at the current bit time, then one idle bit
    task automatic send_frame(input logic [7:0] d, input logic par_bit, input logic stop_bit);
        int bit_clks;
        bit_clks = 16 * (cur_div + 1);
        hold_line(1'b0, bit_clks);
        for (int i = 0; i < 8; i++)
            hold_line(d[i], bit_clks);
        hold_line(par_bit, bit_clks);
        hold_line(stop_bit, bit_clks);
        hold_line(1'b1, bit_clks);
    endtask

    task automatic loopback_byte(input logic [7:0] d);
        logic [31:0] st;
        write_reg(ADR_DATA, {24'd0, d});
        wait_rx_ready(st);
        read_expect(ADR_DATA, expected_read(ADR_DATA, d, ^d, 1'b1), "wb_dat_r DATA");
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        logic [7:0]  b;
        logic [31:0] st;
        logic [7:0]  sent [$];
        rstn       = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        loopback   = 1'b0;
        line_drv   = 1'b1;
        cmp_req    = 1'b0;
        lfsr_state = 32'h51f0_8d7a;
        cur_div    = `UART_DIV_RESET;
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(posedge clk);
        #2;

        // Reset values
        read_expect(ADR_STATUS, 32'd1 << `UART_ST_TX_EMPTY, "wb_dat_r STATUS");
        read_expect(ADR_DIV, 32'(`UART_DIV_RESET), "wb_dat_r DIV");
        read_expect(32'd12, 32'd0, "wb_dat_r offset 3");

        // Loopback of single bytes
        loopback = 1'b1;
        for (int i = 0; i < 16; i++)
        begin
            next_byte(b);
            loopback_byte(b);
        end

        // Parity then framing error from the line driver
        loopback = 1'b0;
        hold_line(1'b1, 16 * (cur_div + 1));
        next_byte(b);
        send_frame(b, !(^b), 1'b1);
        wait_rx_ready(st);
        post_compare("wb_dat_r STATUS", st, expected_read(ADR_STATUS, b, !(^b), 1'b1));
        read_expect(ADR_DATA, expected_read(ADR_DATA, b, !(^b), 1'b1), "wb_dat_r DATA");
        next_byte(b);
        send_frame(b, ^b, 1'b0);
        wait_rx_ready(st);
        post_compare("wb_dat_r STATUS", st, expected_read(ADR_STATUS, b, ^b, 1'b0));
        read_expect(ADR_DATA, expected_read(ADR_DATA, b, ^b, 1'b0), "wb_dat_r DATA");

        // Short low pulse, then a quiet frame time
        hold_line(1'b0, 4 * (cur_div + 1));
        hold_line(1'b1, 11 * 16 * (cur_div + 1));
        read_expect(ADR_STATUS, 32'd1 << `UART_ST_TX_EMPTY, "wb_dat_r STATUS");

        // Fill the transmit FIFO, one byte already on the line
        loopback = 1'b1;
        for (int i = 0; i < `UART_FIFO_DEPTH + 1; i++)
        begin
            next_byte(b);
            sent.push_back(b);
            write_reg(ADR_DATA, {24'd0, b});
        end
        read_expect(ADR_STATUS, 32'd1 << `UART_ST_TX_FULL, "wb_dat_r STATUS");
        next_byte(b);
        write_reg(ADR_DATA, {24'd0, b});
        while (sent.size() > 0)
        begin
            b = sent.pop_front();
            wait_rx_ready(st);
            read_expect(ADR_DATA, expected_read(ADR_DATA, b, ^b, 1'b1), "wb_dat_r DATA");
        end
        repeat (12 * 16 * (cur_div + 1)) @(posedge clk);
        #2;
        read_expect(ADR_STATUS, 32'd1 << `UART_ST_TX_EMPTY, "wb_dat_r STATUS");

        // Slower tick
        write_reg(ADR_DIV, 32'd3);
        cur_div = 3;
        read_expect(ADR_DIV, 32'd3, "wb_dat_r DIV");
        for (int i = 0; i < 4; i++)
        begin
            next_byte(b);
            loopback_byte(b);
        end

        // Let the last compare run
        @(negedge clk);
        @(posedge clk);
        #2;
        if (dut.u_chk.fail_cnt == 0 && !cmp_req)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            $display("ERROR: checks still failing at the end of the run");
            fail_now();
        end
    end

endmodule

// File: test/uart_chk.sv
`timescale 1ns/1ps

module uart_chk (
    input logic clk,
    input logic rstn,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic txd,
    input logic tx_busy,
    input logic tx_push,
    input logic tx_full,
    input logic frame_valid,
    input logic rx_full
);

    int fail_cnt = 0;

    ////////////////////////////////////////
    // Wishbone handshake
    ////////////////////////////////////////

    ack_single : assert property (
        @(posedge clk) disable iff (!rstn)
        wb_ack |=> !wb_ack
    )
    else
    begin
        fail_cnt++;
        $error("wb_ack high in two consecutive cycles");
    end

    // Ack only answers a request seen one cycle earlier
    ack_after_req : assert property (
        @(posedge clk) disable iff (!rstn)
        wb_ack |-> $past(wb_cyc && wb_stb)
    )
    else
    begin
        fail_cnt++;
        $error("wb_ack without a preceding cyc and stb");
    end

    ////////////////////////////////////////
    // Serial line and FIFOs
    ////////////////////////////////////////

    txd_idle_high : assert property (
        @(posedge clk) disable iff (!rstn)
        !tx_busy |-> txd
    )
    else
    begin
        fail_cnt++;
        $error("txd low while the transmitter is idle");
    end

    no_push_full : assert property (
        @(posedge clk) disable iff (!rstn)
        !(tx_push && tx_full) && !(frame_valid && rx_full)
    )
    else
    begin
        fail_cnt++;
        $error("push into a full FIFO");
    end

endmodule

bind uart_top uart_chk u_chk (
    .clk         (clk),
    .rstn        (rstn),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .txd         (txd),
    .tx_busy     (tx_busy),
    .tx_push     (tx_push),
    .tx_full     (tx_full),
    .frame_valid (frame_valid),
    .rx_full     (rx_full)
);

// File: uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      sample_tick,
    input  logic      rxd,
    output logic      frame_valid,
    output rx_frame_t frame
);

    rx_state_t  state;
    logic [3:0] tick_cnt;
    logic [3:0] bit_cnt;
    logic       smp;
    logic       rxd_s;
    logic [8:0] shreg;
    logic       last_tick;

    ////////////////////////////////////////
    // Line sampling
    ////////////////////////////////////////

    // FSM works on the sample one clock after the tick
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            smp <= 1'b0;
        else
            smp <= sample_tick;
    end

    always_ff @(posedge clk)
    begin
        if (sample_tick)
            rxd_s <= rxd;
    end

    assign last_tick = smp && (tick_cnt == 4'd0);

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state    <= RX_IDLE;
            tick_cnt <= 4'd7;
            bit_cnt  <= 4'd8;
        end
        else
        begin
            case (state)
                RX_IDLE:
                begin
                    // Mid-bit of the start bit is 8 ticks away
                    tick_cnt <= 4'd7;
                    if (smp && !rxd_s)
                        state <= RX_START;
                end
                RX_START:
                begin
                    if (smp && tick_cnt != 4'd0)
                        tick_cnt <= tick_cnt - 4'd1;
                    else if (last_tick && rxd_s)
                        state <= RX_IDLE;
                    else if (last_tick)
                    begin
                        state    <= RX_BIT;
                        tick_cnt <= 4'd15;
                        bit_cnt  <= 4'd8;
                    end
                end
                RX_BIT:
                begin
                    if (smp && tick_cnt != 4'd0)
                        tick_cnt <= tick_cnt - 4'd1;
                    else if (last_tick)
                    begin
                        state    <= RX_SHIFT;
                        tick_cnt <= 4'd15;
                    end
                end
                RX_SHIFT:
                begin
                    // A tick here still counts toward the next bit
                    if (smp)
                        tick_cnt <= tick_cnt - 4'd1;
                    if (bit_cnt == 4'd0)
                        state <= RX_STOP;
                    else
                    begin
                        bit_cnt <= bit_cnt - 4'd1;
                        state   <= RX_BIT;
                    end
                end
                RX_STOP:
                begin
                    if (smp && tick_cnt != 4'd0)
                        tick_cnt <= tick_cnt - 4'd1;
                    else if (last_tick)
                        state <= RX_SAVE;
                end
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    // Data and parity LSB first, flags taken at the stop sample
    always_ff @(posedge clk)
    begin
        if (state == RX_BIT && last_tick)
            shreg <= {rxd_s, shreg[8:1]};
        if (state == RX_STOP && last_tick)
            frame <= '{frm_err: ~rxd_s, par_err: ^shreg, data: shreg[7:0]};
    end

    assign frame_valid = (state == RX_SAVE);

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     sample_tick,
    input  logic     tx_empty,
    input  tx_byte_t tx_head,
    output logic     tx_pop,
    output logic     txd,
    output logic     tx_busy
);

    tx_state_t   state;
    logic [10:0] shreg;
    logic [3:0]  tick_cnt;
    logic [3:0]  bit_cnt;

    // Take the next byte as soon as the line is free
    assign tx_pop = (state == TX_IDLE) && !tx_empty;

    // Also busy while a byte waits to be taken
    assign tx_busy = (state != TX_IDLE) || !tx_empty;

    assign txd = shreg[0];

    ////////////////////////////////////////
    // Frame shifter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state    <= TX_IDLE;
            shreg    <= '1;
            tick_cnt <= 4'd0;
            bit_cnt  <= 4'd0;
        end
        else
        begin
            case (state)
                TX_IDLE:
                begin
                    if (tx_pop)
                    begin
                        // Stop, even parity, data, start
                        shreg    <= {1'b1, ^tx_head, tx_head, 1'b0};
                        tick_cnt <= 4'd0;
                        bit_cnt  <= 4'd0;
                        state    <= TX_SEND;
                    end
                end
                TX_SEND:
                begin
                    if (sample_tick)
                    begin
                        tick_cnt <= tick_cnt + 4'd1;
                        if (tick_cnt == 4'd15)
                        begin
                            shreg <= {1'b1, shreg[10:1]};
                            if (bit_cnt == 4'd10)
                                state <= TX_IDLE;
                            else
                                bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

endmodule
